/* hw/ice_cfg_pkg.sv */
`default_nettype none

package ice_cfg_pkg;

	// UART bit period in clock cycles, kept short for simulation
	localparam int CLKS_PER_BIT = 8;
	localparam int CLK_CNT_W    = $clog2(CLKS_PER_BIT);

	// Start bit, eight data bits and one stop bit
	localparam int FRAME_BITS   = 10;

	// Equal samples needed before a button level flips
	localparam int DB_CYCLES    = 16;
	localparam int DB_CNT_W     = $clog2(DB_CYCLES);

	localparam int PB_W         = 4;
	localparam int GPIO_W       = 8;
	localparam int PWR_W        = 3;

endpackage

`default_nettype wire

/* hw/ice_cmd_pkg.sv */
`default_nettype none

package ice_cmd_pkg;

	// Host opcodes, ASCII so a terminal can drive the board
	typedef enum logic [7:0] {
		OP_SET_PWR   = 8'h50,
		OP_SET_GPIO  = 8'h47,
		OP_READ_GPIO = 8'h52,
		OP_READ_PB   = 8'h42
	} ice_op_e;

	localparam logic [7:0] REPLY_OK  = 8'h4B;
	localparam logic [7:0] REPLY_BAD = 8'h3F;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_GET_ARG,
		ST_SEND,
		ST_WAIT_TX
	} ctrl_state_e;

endpackage

`default_nettype wire

/* hw/uart_rx.sv */
`default_nettype none
`timescale 1ns/100ps

module uart_rx import ice_cfg_pkg::*; (
	input  wire        clk,
	input  wire        arst_n,
	input  wire        rx,
	output logic [7:0] rx_data,
	output logic       rx_valid
);

	logic [1:0]           rx_sync;
	logic                 rx_s;
	logic                 rx_prev;
	logic                 busy;
	logic [3:0]           bit_idx;
	logic [CLK_CNT_W-1:0] clk_cnt;
	logic [7:0]           shift_q;
	logic                 sample_now;

	assign rx_s = rx_sync[1];

	// Start bit checked after half a bit, later bits one full bit apart
	assign sample_now = (bit_idx == 4'd0) ?
		(clk_cnt == CLK_CNT_W'(CLKS_PER_BIT / 2 - 1)) :
		(clk_cnt == CLK_CNT_W'(CLKS_PER_BIT - 1));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rx_sync  <= 2'b11;
			rx_prev  <= 1'b1;
			busy     <= 1'b0;
			bit_idx  <= '0;
			clk_cnt  <= '0;
			rx_valid <= 1'b0;
			rx_data  <= '0;
		end else begin
			rx_sync  <= {rx_sync[0], rx};
			rx_prev  <= rx_s;
			rx_valid <= 1'b0;
			if (!busy) begin
				// Falling edge marks a possible start bit
				if (rx_prev && !rx_s) begin
					busy    <= 1'b1;
					bit_idx <= '0;
					clk_cnt <= '0;
				end
			end else if (sample_now) begin
				clk_cnt <= '0;
				bit_idx <= bit_idx + 4'd1;
				if (bit_idx == 4'd0) begin
					// Line back high at mid start bit, treat as glitch
					if (rx_s) begin
						busy <= 1'b0;
					end
				end else if (bit_idx == 4'd9) begin
					busy <= 1'b0;
					// Low stop bit means framing error, drop the byte
					if (rx_s) begin
						rx_data  <= shift_q;
						rx_valid <= 1'b1;
					end
				end
			end else begin
				clk_cnt <= clk_cnt + 1'b1;
			end
		end
	end

	// LSB arrives first
	always_ff @(posedge clk) begin
		if (busy && sample_now && bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
			shift_q <= {rx_s, shift_q[7:1]};
		end
	end

endmodule

`default_nettype wire

/* hw/uart_tx.sv */
`default_nettype none
`timescale 1ns/100ps

module uart_tx import ice_cfg_pkg::*; (
	input  wire        clk,
	input  wire        arst_n,
	input  wire        tx_start,
	input  wire  [7:0] tx_data,
	output logic       tx,
	output logic       tx_busy
);

	logic [FRAME_BITS-1:0] shreg;
	logic [CLK_CNT_W-1:0]  clk_cnt;
	logic [3:0]            bit_cnt;

	// Shift register idles at all ones so the line rests high
	assign tx = shreg[0];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			shreg   <= '1;
			clk_cnt <= '0;
			bit_cnt <= '0;
			tx_busy <= 1'b0;
		end else if (!tx_busy) begin
			if (tx_start) begin
				shreg   <= {1'b1, tx_data, 1'b0};
				clk_cnt <= '0;
				bit_cnt <= '0;
				tx_busy <= 1'b1;
			end
		end else if (clk_cnt == CLK_CNT_W'(CLKS_PER_BIT - 1)) begin
			clk_cnt <= '0;
			shreg   <= {1'b1, shreg[FRAME_BITS-1:1]};
			// Busy drops as the stop bit ends
			if (bit_cnt == 4'(FRAME_BITS - 1)) begin
				tx_busy <= 1'b0;
			end else begin
				bit_cnt <= bit_cnt + 4'd1;
			end
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* hw/pb_debounce.sv */
`default_nettype none
`timescale 1ns/100ps

module pb_debounce import ice_cfg_pkg::*; (
	input  wire             clk,
	input  wire             arst_n,
	input  wire  [PB_W-1:0] pb_n,
	output logic [PB_W-1:0] pb_level
);

	logic [PB_W-1:0]     sync1;
	logic [PB_W-1:0]     sync2;
	logic [DB_CNT_W-1:0] cnt [PB_W];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			// Buttons are active low, so released reads as ones
			sync1    <= '1;
			sync2    <= '1;
			pb_level <= '0;
			for (int i = 0; i < PB_W; i++) begin
				cnt[i] <= '0;
			end
		end else begin
			sync1 <= pb_n;
			sync2 <= sync1;
			for (int i = 0; i < PB_W; i++) begin
				if (!sync2[i] == pb_level[i]) begin
					cnt[i] <= '0;
				end else if (cnt[i] == DB_CNT_W'(DB_CYCLES - 1)) begin
					// Held long enough, accept new level
					pb_level[i] <= !sync2[i];
					cnt[i]      <= '0;
				end else begin
					cnt[i] <= cnt[i] + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* hw/ice_io_regs.sv */
`default_nettype none
`timescale 1ns/100ps

module ice_io_regs import ice_cfg_pkg::*; (
	input  wire               clk,
	input  wire               arst_n,
	input  wire               clear_req,
	input  wire               wr_pwr,
	input  wire               wr_gpio,
	input  wire  [7:0]        wr_value,
	input  wire  [GPIO_W-1:0] gpio_in,
	output logic [GPIO_W-1:0] gpio_sync,
	output logic [GPIO_W-1:0] gpio_out,
	output logic              m3_0p6_sw,
	output logic              m3_1p2_sw,
	output logic              m3_vbatt_sw
);

	logic [PWR_W-1:0]  pwr_q;
	logic [GPIO_W-1:0] gpio_meta;

	// Bit 0 is 0.6 V, bit 1 is 1.2 V, bit 2 is battery
	assign m3_0p6_sw   = pwr_q[0];
	assign m3_1p2_sw   = pwr_q[1];
	assign m3_vbatt_sw = pwr_q[2];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pwr_q    <= '0;
			gpio_out <= '0;
		end else if (clear_req) begin
			// PB[1] held, keep everything off
			pwr_q    <= '0;
			gpio_out <= '0;
		end else begin
			if (wr_pwr) begin
				pwr_q <= wr_value[PWR_W-1:0];
			end
			if (wr_gpio) begin
				gpio_out <= wr_value[GPIO_W-1:0];
			end
		end
	end

	// Two-flop synchronizer for readback
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			gpio_meta <= '0;
			gpio_sync <= '0;
		end else begin
			gpio_meta <= gpio_in;
			gpio_sync <= gpio_meta;
		end
	end

endmodule

`default_nettype wire

/* hw/ice_cmd_ctrl.sv */
`default_nettype none
`timescale 1ns/100ps

module ice_cmd_ctrl import ice_cfg_pkg::*, ice_cmd_pkg::*; (
	input  wire               clk,
	input  wire               arst_n,
	input  wire  [7:0]        rx_data,
	input  wire               rx_valid,
	input  wire  [GPIO_W-1:0] gpio_sync,
	input  wire  [PB_W-1:0]   pb_level,
	input  wire               tx_busy,
	output logic [7:0]        tx_data,
	output logic              tx_start,
	output logic              wr_pwr,
	output logic              wr_gpio,
	output logic [7:0]        wr_value
);

	ctrl_state_e state;
	ice_op_e     op_q;
	logic [7:0]  arg_q;
	logic        op_has_arg;

	// Only the two set commands carry an operand byte
	assign op_has_arg = (ice_op_e'(rx_data) == OP_SET_PWR) ||
		(ice_op_e'(rx_data) == OP_SET_GPIO);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
			op_q  <= OP_READ_PB;
			arg_q <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (rx_valid) begin
						op_q  <= ice_op_e'(rx_data);
						state <= op_has_arg ? ST_GET_ARG : ST_SEND;
					end
				end
				ST_GET_ARG: begin
					if (rx_valid) begin
						arg_q <= rx_data;
						state <= ST_SEND;
					end
				end
				ST_SEND: begin
					if (!tx_busy) begin
						state <= ST_WAIT_TX;
					end
				end
				ST_WAIT_TX: begin
					// Bytes arriving here are dropped
					if (!tx_busy) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Register write shares the cycle with the reply start
	always_comb begin
		tx_start = (state == ST_SEND) && !tx_busy;
		wr_pwr   = tx_start && (op_q == OP_SET_PWR);
		wr_gpio  = tx_start && (op_q == OP_SET_GPIO);
		case (op_q)
			OP_SET_PWR,
			OP_SET_GPIO:  tx_data = REPLY_OK;
			OP_READ_GPIO: tx_data = 8'(gpio_sync);
			OP_READ_PB:   tx_data = 8'(pb_level);
			default:      tx_data = REPLY_BAD;
		endcase
	end

	assign wr_value = arg_q;

endmodule

`default_nettype wire

/* hw/ice_top.sv */
`default_nettype none
`timescale 1ns/100ps

module ice_top import ice_cfg_pkg::*; (
	input  wire               clk,
	input  wire               arst_n,
	input  wire               uart_rxd,
	output logic              uart_txd,
	input  wire  [PB_W-1:0]   pb_n,
	input  wire  [GPIO_W-1:0] gpio_in,
	output logic [GPIO_W-1:0] gpio_out,
	output logic              m3_0p6_sw,
	output logic              m3_1p2_sw,
	output logic              m3_vbatt_sw
);

	logic [7:0]        rx_data;
	logic              rx_valid;
	logic [7:0]        tx_data;
	logic              tx_start;
	logic              tx_busy;
	logic              wr_pwr;
	logic              wr_gpio;
	logic [7:0]        wr_value;
	logic [GPIO_W-1:0] gpio_sync;
	logic [PB_W-1:0]   pb_level;

	uart_rx u_rx (
		.clk      (clk),
		.arst_n   (arst_n),
		.rx       (uart_rxd),
		.rx_data  (rx_data),
		.rx_valid (rx_valid)
	);

	uart_tx u_tx (
		.clk      (clk),
		.arst_n   (arst_n),
		.tx_start (tx_start),
		.tx_data  (tx_data),
		.tx       (uart_txd),
		.tx_busy  (tx_busy)
	);

	pb_debounce u_db (
		.clk      (clk),
		.arst_n   (arst_n),
		.pb_n     (pb_n),
		.pb_level (pb_level)
	);

	// PB[1] doubles as a soft clear of the output registers
	ice_io_regs u_regs (
		.clk         (clk),
		.arst_n      (arst_n),
		.clear_req   (pb_level[0]),
		.wr_pwr      (wr_pwr),
		.wr_gpio     (wr_gpio),
		.wr_value    (wr_value),
		.gpio_in     (gpio_in),
		.gpio_sync   (gpio_sync),
		.gpio_out    (gpio_out),
		.m3_0p6_sw   (m3_0p6_sw),
		.m3_1p2_sw   (m3_1p2_sw),
		.m3_vbatt_sw (m3_vbatt_sw)
	);

	ice_cmd_ctrl u_ctrl (
		.clk       (clk),
		.arst_n    (arst_n),
		.rx_data   (rx_data),
		.rx_valid  (rx_valid),
		.gpio_sync (gpio_sync),
		.pb_level  (pb_level),
		.tx_busy   (tx_busy),
		.tx_data   (tx_data),
		.tx_start  (tx_start),
		.wr_pwr    (wr_pwr),
		.wr_gpio   (wr_gpio),
		.wr_value  (wr_value)
	);

endmodule

`default_nettype wire

/* testbench/tb_ice_tasks.svh */
`ifndef TB_ICE_TASKS_SVH
`define TB_ICE_TASKS_SVH

// Galois LFSR, one step per random bit
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] val;
	val = '0;
	for (int i = 0; i < n; i++) begin
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
		val = {val[30:0], lfsr[0]};
	end
	return val;
endfunction

// Host side serializer, LSB first
task automatic send_byte(input logic [7:0] data);
	logic [FRAME_BITS-1:0] frame;
	frame = {1'b1, data, 1'b0};
	for (int i = 0; i < FRAME_BITS; i++) begin
		@(negedge clk);
		uart_rxd = frame[i];
		repeat (CLKS_PER_BIT - 1) @(negedge clk);
	end
endtask

// Start edge seen half a cycle late, then every bit sampled near its middle
task automatic recv_byte(output logic [7:0] data, output logic frame_ok);
	@(negedge clk);
	while (uart_txd !== 1'b0) @(negedge clk);
	repeat (CLKS_PER_BIT / 2) @(negedge clk);
	frame_ok = (uart_txd === 1'b0);
	for (int i = 0; i < 8; i++) begin
		repeat (CLKS_PER_BIT) @(negedge clk);
		data[i] = uart_txd;
	end
	repeat (CLKS_PER_BIT) @(negedge clk);
	frame_ok = frame_ok && (uart_txd === 1'b1);
endtask

// Reply the host protocol calls for
function automatic logic [7:0] model_reply(input logic [7:0] op);
	case (op)
		OP_SET_PWR, OP_SET_GPIO: return REPLY_OK;
		OP_READ_GPIO: return mdl_gpio_in;
		OP_READ_PB: return {4'h0, ~mdl_pb_n};
		default: return REPLY_BAD;
	endcase
endfunction

function automatic void model_write(input logic [7:0] op, input logic [7:0] arg);
	if (op == OP_SET_PWR) begin
		mdl_pwr = arg[PWR_W-1:0];
	end
	if (op == OP_SET_GPIO) begin
		mdl_gpio = arg;
	end
endfunction

`endif

/* testbench/tb_ice_top.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_ice_top import ice_cfg_pkg::*, ice_cmd_pkg::*; ();

	localparam int N_RAND      = 20;
	localparam int N_READ      = 10;
	localparam int N_CMDS      = 2 * N_RAND + 5 * N_READ + 3;
	// Two bytes per command, four times over
	localparam int WATCHDOG_NS = N_CMDS * 2 * FRAME_BITS * CLKS_PER_BIT * 20 * 4;
	localparam int REPLY_WAIT  = 3 * FRAME_BITS * CLKS_PER_BIT;
	localparam int SETTLE      = DB_CYCLES + 8;

	logic              clk;
	logic              arst_n;
	logic              uart_rxd;
	logic              uart_txd;
	logic [PB_W-1:0]   pb_n;
	logic [GPIO_W-1:0] gpio_in;
	logic [GPIO_W-1:0] gpio_out;
	logic              m3_0p6_sw;
	logic              m3_1p2_sw;
	logic              m3_vbatt_sw;

	logic [31:0]       lfsr = 32'h4161;
	logic [7:0]        reply_q[$];
	logic [GPIO_W-1:0] mdl_gpio;
	logic [GPIO_W-1:0] mdl_gpio_in;
	logic [PWR_W-1:0]  mdl_pwr;
	logic [PB_W-1:0]   mdl_pb_n;
	int                test_errs;
	int                pass_count;
	int                fail_count;

	`include "tb_ice_tasks.svh"

	ice_top uut (
		.clk         (clk),
		.arst_n      (arst_n),
		.uart_rxd    (uart_rxd),
		.uart_txd    (uart_txd),
		.pb_n        (pb_n),
		.gpio_in     (gpio_in),
		.gpio_out    (gpio_out),
		.m3_0p6_sw   (m3_0p6_sw),
		.m3_1p2_sw   (m3_1p2_sw),
		.m3_vbatt_sw (m3_vbatt_sw)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("** Error: %s expected %h actual %h at %0t", name, exp, act, $time);
			test_errs++;
		end
	endtask

	task automatic check_outputs();
		check_byte("gpio_out", mdl_gpio, gpio_out);
		check_byte("m3_vbatt/1p2/0p6_sw", 8'(mdl_pwr),
			8'({m3_vbatt_sw, m3_1p2_sw, m3_0p6_sw}));
	endtask

	task automatic end_test(input string name);
		if (test_errs == 0) begin
			pass_count++;
			$display("%s: ok", name);
		end else begin
			fail_count++;
			$display("%s: %0d errors", name, test_errs);
		end
		test_errs = 0;
	endtask

	// One command, reply checked against the model
	task automatic run_cmd(input logic [7:0] op, input logic [7:0] arg);
		int waited;
		waited = 0;
		send_byte(op);
		if (op == OP_SET_PWR || op == OP_SET_GPIO) begin
			send_byte(arg);
		end
		while (reply_q.size() == 0 && waited < REPLY_WAIT) begin
			@(negedge clk);
			waited++;
		end
		if (reply_q.size() == 0) begin
			$display("No reply to opcode %h within %0d cycles", op, REPLY_WAIT);
			test_errs++;
		end else begin
			check_byte("uart_txd", model_reply(op), reply_q.pop_front());
		end
		model_write(op, arg);
	endtask

	initial begin : reply_monitor
		logic [7:0] data;
		logic       ok;
		wait (arst_n === 1'b1);
		forever begin
			recv_byte(data, ok);
			if (!ok) begin
				$display("Reply byte %h on uart_txd had a bad start or stop bit", data);
				test_errs++;
			end
			reply_q.push_back(data);
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, run stopped", WATCHDOG_NS);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin : main_seq
		logic [7:0] val;
		logic [3:0] mask;
		arst_n      = 1'b0;
		uart_rxd    = 1'b1;
		pb_n        = '1;
		gpio_in     = '0;
		mdl_gpio    = '0;
		mdl_gpio_in = '0;
		mdl_pwr     = '0;
		mdl_pb_n    = '1;
		test_errs   = 0;
		pass_count  = 0;
		fail_count  = 0;
		repeat (2) @(negedge clk);
		arst_n = 1'b1;
		repeat (4) @(negedge clk);

		for (int i = 0; i < N_RAND; i++) begin
			run_cmd(OP_SET_PWR, 8'(rand_bits(8)));
			check_outputs();
		end
		end_test("set_pwr");

		for (int i = 0; i < N_RAND; i++) begin
			run_cmd(OP_SET_GPIO, 8'(rand_bits(8)));
			check_outputs();
		end
		end_test("set_gpio");

		for (int i = 0; i < N_READ; i++) begin
			gpio_in = GPIO_W'(rand_bits(GPIO_W));
			mdl_gpio_in = gpio_in;
			repeat (4) @(negedge clk);
			run_cmd(OP_READ_GPIO, 8'h00);
		end
		end_test("read_gpio");

		// PB[1] stays released throughout
		for (int i = 0; i < N_READ; i++) begin
			val = 8'(rand_bits(3));
			pb_n = {val[2:0], 1'b1};
			mdl_pb_n = pb_n;
			repeat (SETTLE) @(negedge clk);
			run_cmd(OP_READ_PB, 8'h00);
			// Glitch shorter than the debounce window
			mask = {3'(rand_bits(3)), 1'b0};
			if (mask == '0) begin
				mask = 4'b0010;
			end
			fork
				run_cmd(OP_READ_PB, 8'h00);
				begin
					// Spans the cycle where the reply byte is latched
					repeat ((FRAME_BITS - 1) * CLKS_PER_BIT + 1) @(negedge clk);
					pb_n = mdl_pb_n ^ mask;
					repeat (DB_CYCLES / 2) @(negedge clk);
					pb_n = mdl_pb_n;
				end
			join
		end
		end_test("read_pb");

		for (int i = 0; i < N_READ; i++) begin
			val = 8'(rand_bits(8));
			while (val == OP_SET_PWR || val == OP_SET_GPIO ||
				val == OP_READ_GPIO || val == OP_READ_PB) begin
				val = 8'(rand_bits(8));
			end
			run_cmd(val, 8'h00);
			run_cmd(OP_SET_GPIO, 8'(rand_bits(8)));
			check_outputs();
		end
		end_test("bad_opcode");

		run_cmd(OP_SET_PWR, 8'(rand_bits(8)) | 8'h01);
		run_cmd(OP_SET_GPIO, 8'(rand_bits(8)) | 8'h80);
		check_outputs();
		pb_n[0] = 1'b0;
		repeat (SETTLE) @(negedge clk);
		mdl_pwr = '0;
		mdl_gpio = '0;
		check_outputs();
		pb_n[0] = 1'b1;
		repeat (SETTLE) @(negedge clk);
		run_cmd(OP_SET_GPIO, 8'(rand_bits(8)) | 8'h01);
		check_outputs();
		end_test("pb1_clear");

		$display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
+incdir+testbench
hw/ice_cfg_pkg.sv
hw/ice_cmd_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/pb_debounce.sv
hw/ice_io_regs.sv
hw/ice_cmd_ctrl.sv
hw/ice_top.sv
testbench/tb_ice_top.sv
